// ==== logic/decode_pkg.sv ====
package decode_pkg;

    localparam int XLEN = 32;

    // major opcodes, zero marks a bubble
    typedef enum logic [6:0] {
        opc_none   = 7'b0000000,
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_eq   = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        sel1_reg  = 2'd0,
        sel1_pc   = 2'd1,
        sel1_zero = 2'd2 // lui adds the immediate to zero
    } src1_sel_e;

    typedef enum logic [1:0] {
        sel2_imm       = 2'd0,
        sel2_reg       = 2'd1,
        sel2_csr_set   = 2'd2, // csrrs
        sel2_csr_write = 2'd3  // csrrw
    } src2_sel_e;

    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam int          CSR_COUNT   = 4; // one-hot order mepc, mcause, mstatus, mtvec

    localparam logic [31:0] ECALL_WORD   = 32'h0000_0073;
    localparam logic [31:0] MRET_WORD    = 32'h3020_0073;
    localparam logic [31:0] FENCE_I_WORD = 32'h0000_100f;

    localparam logic [XLEN-1:0] MCAUSE_ECALL = 32'd11; // environment call from M-mode

endpackage

// ==== logic/inst_latch.sv ====
`timescale 1ns/1ps

module inst_latch
    import decode_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            flush,
    input  logic            valid_in,
    input  logic            ready_out,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] pc,
    output logic            ready_in,
    output logic            valid_out,
    output logic [31:0]     inst_q,
    output logic [XLEN-1:0] pc_q
);

    logic flush_pending;
    logic transfer;
    logic kill;

    assign ready_in = ready_out; // single stage, no buffering of its own
    assign transfer = valid_in & ready_in;
    assign kill     = flush | flush_pending;

    // a flush seen while idle waits for the next transfer
    always_ff @(posedge clock) begin
        if (reset) begin
            flush_pending <= 1'b0;
        end else if (transfer) begin
            flush_pending <= 1'b0;
        end else if (flush) begin
            flush_pending <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_out <= 1'b0;
            inst_q    <= '0;
            pc_q      <= '0;
        end else begin
            valid_out <= transfer & ~kill; // one-cycle pulse
            if (transfer) begin
                inst_q <= kill ? '0 : inst; // bubble on flush
                pc_q   <= pc;
            end
        end
    end

endmodule

// ==== logic/ctrl_decoder.sv ====
`timescale 1ns/1ps

module ctrl_decoder
    import decode_pkg::*;
(
    input  logic [31:0]          inst_q,
    input  logic [XLEN-1:0]      imm,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd_out,
    output logic [2:0]           funct3,
    output alu_op_e              alu_op,
    output src1_sel_e            src1_sel,
    output src2_sel_e            src2_sel,
    output logic                 mem_wen,
    output logic                 mem_ren,
    output logic                 branch_flag,
    output logic                 inv_flag,
    output logic                 jump_flag,
    output logic                 reg_wen_out,
    output logic [CSR_COUNT-1:0] csr_wen_out,
    output logic                 ecall_flag,
    output logic                 mret_flag,
    output logic                 fence_i_flag
);

    opcode_e opcode;
    logic    funct7_5;
    logic    is_system;

    assign opcode   = opcode_e'(inst_q[6:0]);
    assign funct7_5 = inst_q[30]; // sub / sra select
    assign rs1      = inst_q[19:15];
    assign rs2      = inst_q[24:20];
    assign rd_out   = inst_q[11:7];
    assign funct3   = inst_q[14:12];

    always_comb begin
        alu_op   = alu_add;
        src1_sel = sel1_reg;
        src2_sel = sel2_imm;
        case (opcode)
            opc_op, opc_op_imm: begin
                if (opcode == opc_op) begin
                    src2_sel = sel2_reg;
                end
                case (funct3)
                    3'b000: alu_op = (opcode == opc_op && funct7_5) ? alu_sub : alu_add;
                    3'b001: alu_op = alu_sll;
                    3'b010: alu_op = alu_slt;
                    3'b011: alu_op = alu_sltu;
                    3'b100: alu_op = alu_xor;
                    3'b101: alu_op = funct7_5 ? alu_sra : alu_srl;
                    3'b110: alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            opc_branch: begin
                src2_sel = sel2_reg;
                case (funct3[2:1])
                    2'b00:   alu_op = alu_eq;   // beq, bne
                    2'b10:   alu_op = alu_slt;  // blt, bge
                    2'b11:   alu_op = alu_sltu; // bltu, bgeu
                    default: alu_op = alu_add;
                endcase
            end
            opc_lui:            src1_sel = sel1_zero;
            opc_auipc, opc_jal: src1_sel = sel1_pc;
            opc_system: begin
                if (funct3 == 3'b010) begin
                    alu_op   = alu_or;
                    src2_sel = sel2_csr_set;
                end else if (funct3 == 3'b001) begin
                    src2_sel = sel2_csr_write;
                end
            end
            default: ;
        endcase
    end

    assign mem_wen     = (opcode == opc_store);
    assign mem_ren     = (opcode == opc_load);
    assign branch_flag = (opcode == opc_branch);
    assign jump_flag   = (opcode == opc_jal) || (opcode == opc_jalr);
    // inverted compare result for bne, bge, bgeu
    assign inv_flag    = branch_flag && (funct3 == 3'b001 || funct3 == 3'b101 || funct3 == 3'b111);
    assign reg_wen_out = !(mem_wen || branch_flag || opcode == opc_none);

    assign is_system      = (opcode == opc_system);
    assign csr_wen_out[0] = is_system && (imm == XLEN'(CSR_MEPC));
    assign csr_wen_out[1] = is_system && (imm == XLEN'(CSR_MCAUSE));
    assign csr_wen_out[2] = is_system && (imm == XLEN'(CSR_MSTATUS));
    assign csr_wen_out[3] = is_system && (imm == XLEN'(CSR_MTVEC));

    assign ecall_flag   = (inst_q == ECALL_WORD);
    assign mret_flag    = (inst_q == MRET_WORD);
    assign fence_i_flag = (inst_q == FENCE_I_WORD);

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen
    import decode_pkg::*;
(
    input  logic [31:0]     inst_q,
    output logic [XLEN-1:0] imm
);

    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm_r;

    assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign imm_b = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    assign imm_u = {inst_q[31:12], 12'b0};
    assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
    assign imm_r = {25'b0, inst_q[31:25]}; // raw funct7 for op

    always_comb begin
        case (opcode_e'(inst_q[6:0]))
            opc_op:                                      imm = imm_r;
            opc_op_imm, opc_load, opc_jalr, opc_system: imm = imm_i; // csr address for system
            opc_store:                                   imm = imm_s;
            opc_branch:                                  imm = imm_b;
            opc_lui, opc_auipc:                          imm = imm_u;
            opc_jal:                                     imm = imm_j;
            default:                                     imm = '0;
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import decode_pkg::*;
#(
    parameter int REG_ADDR_W = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_value,
    input  logic                  wb_reg_wen,
    output logic [XLEN-1:0]       rs1_value,
    output logic [XLEN-1:0]       rs2_value
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_reg_wen && wb_rd != '0) begin // x0 stays zero
            regs[wb_rd] <= wb_value;
        end
    end

    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps

module csr_file
    import decode_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [XLEN-1:0]      pc_q,
    input  logic                 ecall_flag,
    input  logic [11:0]          csr_addr,
    input  logic [CSR_COUNT-1:0] wb_csr_wen,
    input  logic [XLEN-1:0]      wb_csr_value,
    output logic [XLEN-1:0]      csr_value,
    output logic [XLEN-1:0]      mepc_out,
    output logic [XLEN-1:0]      mtvec_out
);

    logic [XLEN-1:0] mepc, mcause, mstatus, mtvec;

    always_ff @(posedge clock) begin
        if (reset) begin
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= '0;
            mtvec   <= '0;
        end else begin
            if (ecall_flag) begin
                mepc   <= pc_q;
                mcause <= MCAUSE_ECALL;
            end
            // writeback comes last so it overrides the trap capture
            if (wb_csr_wen[0]) mepc    <= wb_csr_value;
            if (wb_csr_wen[1]) mcause  <= wb_csr_value;
            if (wb_csr_wen[2]) mstatus <= wb_csr_value;
            if (wb_csr_wen[3]) mtvec   <= wb_csr_value;
        end
    end

    always_comb begin
        case (csr_addr)
            CSR_MEPC:    csr_value = mepc;
            CSR_MCAUSE:  csr_value = mcause;
            CSR_MSTATUS: csr_value = mstatus;
            CSR_MTVEC:   csr_value = mtvec;
            default:     csr_value = '0;
        endcase
    end

    assign mepc_out  = mepc;
    assign mtvec_out = mtvec; // trap target for fetch

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
#(
    parameter int REG_ADDR_W = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 valid_in,
    output logic                 ready_in,
    input  logic [31:0]          inst,
    input  logic [XLEN-1:0]      pc,
    input  logic                 ready_out,
    output logic                 valid_out,
    input  logic [4:0]           wb_rd,
    input  logic [XLEN-1:0]      wb_value,
    input  logic                 wb_reg_wen,
    input  logic [XLEN-1:0]      wb_csr_value,
    input  logic [CSR_COUNT-1:0] wb_csr_wen,
    output logic [XLEN-1:0]      pc_out,
    output logic [XLEN-1:0]      imm,
    output logic [XLEN-1:0]      rs1_value,
    output logic [XLEN-1:0]      rs2_value,
    output logic [XLEN-1:0]      csr_value,
    output logic [XLEN-1:0]      mepc_out,
    output logic [XLEN-1:0]      mtvec_out,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd_out,
    output logic [2:0]           funct3,
    output alu_op_e              alu_op,
    output src1_sel_e            src1_sel,
    output src2_sel_e            src2_sel,
    output logic                 mem_wen,
    output logic                 mem_ren,
    output logic                 branch_flag,
    output logic                 inv_flag,
    output logic                 jump_flag,
    output logic                 reg_wen_out,
    output logic [CSR_COUNT-1:0] csr_wen_out,
    output logic                 ecall_flag,
    output logic                 mret_flag,
    output logic                 fence_i_flag
);

    logic [31:0] inst_q;

    inst_latch latch0 (
        .clock(clock), .reset(reset), .flush(flush),
        .valid_in(valid_in), .ready_out(ready_out), .inst(inst), .pc(pc),
        .ready_in(ready_in), .valid_out(valid_out), .inst_q(inst_q), .pc_q(pc_out)
    );

    ctrl_decoder decoder0 (
        .inst_q(inst_q), .imm(imm),
        .rs1(rs1), .rs2(rs2), .rd_out(rd_out), .funct3(funct3),
        .alu_op(alu_op), .src1_sel(src1_sel), .src2_sel(src2_sel),
        .mem_wen(mem_wen), .mem_ren(mem_ren), .branch_flag(branch_flag),
        .inv_flag(inv_flag), .jump_flag(jump_flag),
        .reg_wen_out(reg_wen_out), .csr_wen_out(csr_wen_out),
        .ecall_flag(ecall_flag), .mret_flag(mret_flag), .fence_i_flag(fence_i_flag)
    );

    imm_gen imm_gen0 (
        .inst_q(inst_q),
        .imm(imm)
    );

    // RV32E keeps only the low index bits
    reg_file #(.REG_ADDR_W(REG_ADDR_W)) regs0 (
        .clock(clock), .reset(reset),
        .rs1(rs1[REG_ADDR_W-1:0]), .rs2(rs2[REG_ADDR_W-1:0]), .wb_rd(wb_rd[REG_ADDR_W-1:0]),
        .wb_value(wb_value), .wb_reg_wen(wb_reg_wen),
        .rs1_value(rs1_value), .rs2_value(rs2_value)
    );

    csr_file csrs0 (
        .clock(clock), .reset(reset), .pc_q(pc_out), .ecall_flag(ecall_flag),
        .csr_addr(imm[11:0]), .wb_csr_wen(wb_csr_wen), .wb_csr_value(wb_csr_value),
        .csr_value(csr_value), .mepc_out(mepc_out), .mtvec_out(mtvec_out)
    );

endmodule

// ==== bench/decode_stage_sva.sv ====
`timescale 1ns/1ps

module decode_stage_sva (
    input logic        clock,
    input logic        reset,
    input logic        valid_in,
    input logic        ready_in,
    input logic        valid_out,
    input logic [31:0] inst_q,
    input logic        reg_wen_out
);

    // a pulse needs an accepted transfer one cycle earlier
    a_valid_after_transfer: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> $past(valid_in && ready_in))
        else $error("valid_out without an accepted transfer");

    a_idle_after_reset: assert property (@(posedge clock) $fell(reset) |-> !valid_out)
        else $error("valid_out high right after reset");

    // stores and branches never write a register
    a_no_wen_store_branch: assert property (@(posedge clock) disable iff (reset)
        (inst_q[6:0] == 7'b0100011 || inst_q[6:0] == 7'b1100011) |-> !reg_wen_out)
        else $error("reg_wen_out high for store or branch");

endmodule

bind decode_stage decode_stage_sva sva0 (
    .clock(clock), .reset(reset), .valid_in(valid_in), .ready_in(ready_in),
    .valid_out(valid_out), .inst_q(inst_q), .reg_wen_out(reg_wen_out)
);

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb
    import decode_pkg::*;
;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // rough cycle cost of each directed test, summed
    localparam int RUN_CYCLES   = RESET_CYCLES + 12 + 40 + 80 + 10 + 30;

    logic              clock, reset, flush, valid_in, ready_in, ready_out, valid_out;
    logic [31:0]       inst, pc, wb_value, wb_csr_value;
    logic [4:0]        wb_rd;
    logic              wb_reg_wen;
    logic [3:0]        wb_csr_wen;
    logic [31:0]       pc_out, imm, rs1_value, rs2_value, csr_value, mepc_out, mtvec_out;
    logic [4:0]        rs1, rs2, rd_out;
    logic [2:0]        funct3;
    alu_op_e           alu_op;
    src1_sel_e         src1_sel;
    src2_sel_e         src2_sel;
    logic              mem_wen, mem_ren, branch_flag, inv_flag, jump_flag, reg_wen_out;
    logic [3:0]        csr_wen_out;
    logic              ecall_flag, mret_flag, fence_i_flag;

    logic [31:0] lfsr_state = 32'h664131f3;
    logic [31:0] reg_model [16];
    int          check_count = 0;
    int          error_count = 0;

    decode_stage #(.REG_ADDR_W(4)) dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    // RV32 alu selection by opcode, funct3 and funct7 bit 5
    function automatic alu_op_e expected_alu(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic f7_5);
        alu_op_e r;
        r = alu_add;
        if (opc == 7'b0110011 || opc == 7'b0010011) begin
            case (f3)
                3'd0: r = (opc == 7'b0110011 && f7_5) ? alu_sub : alu_add;
                3'd1: r = alu_sll;
                3'd2: r = alu_slt;
                3'd3: r = alu_sltu;
                3'd4: r = alu_xor;
                3'd5: r = f7_5 ? alu_sra : alu_srl;
                3'd6: r = alu_or;
                default: r = alu_and;
            endcase
        end else if (opc == 7'b1100011) begin
            r = f3[2] ? (f3[1] ? alu_sltu : alu_slt) : alu_eq;
        end else if (opc == 7'b1110011 && f3 == 3'b010) begin
            r = alu_or;
        end
        return r;
    endfunction

    // one accepted transfer, checked on the following falling edge
    task automatic send(input logic [31:0] word, input logic [31:0] addr, input logic want_valid);
        @(posedge clock);
        valid_in <= 1'b1;
        inst     <= word;
        pc       <= addr;
        @(posedge clock);
        valid_in <= 1'b0;
        @(negedge clock);
        check(32'(valid_out), 32'(want_valid), "valid_out after transfer");
    endtask

    task automatic reset_and_handshake;
        @(negedge clock);
        check(32'(valid_out), 32'd0, "valid_out after reset");
        check(32'(reg_wen_out), 32'd0, "reg_wen_out after reset");
        check(32'({mem_wen, mem_ren}), 32'd0, "memory flags after reset");
        send({12'd7, 5'd2, 3'b000, 5'd1, 7'b0010011}, 32'h40, 1'b1);
        @(negedge clock);
        check(32'(valid_out), 32'd0, "valid_out second cycle");
        @(posedge clock);
        ready_out <= 1'b0; // back-pressure with a load waiting
        valid_in  <= 1'b1;
        inst      <= {12'd4, 5'd2, 3'b010, 5'd3, 7'b0000011};
        repeat (3) begin
            @(negedge clock);
            check(32'(valid_out), 32'd0, "valid_out under back-pressure");
            check(32'(ready_in), 32'd0, "ready_in under back-pressure");
            check(32'(mem_ren), 32'd0, "latch held under back-pressure");
        end
        @(posedge clock);
        valid_in  <= 1'b0;
        ready_out <= 1'b1;
    endtask

    task automatic register_readback;
        logic [3:0]  r1, r2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        f7_5;
        logic [31:0] value, addr;
        for (int i = 0; i < 16; i++) begin
            value = random_bits(32);
            reg_model[i] = (i == 0) ? 32'd0 : value; // x0 drops the write
            @(posedge clock);
            wb_reg_wen <= 1'b1;
            wb_rd      <= 5'(i);
            wb_value   <= value;
        end
        @(posedge clock);
        wb_reg_wen <= 1'b0;
        for (int n = 0; n < 8; n++) begin
            r1   = (n == 0) ? 4'd0 : 4'(random_bits(4));
            r2   = 4'(random_bits(4));
            rd   = 5'(random_bits(5));
            f3   = 3'(random_bits(3));
            f7_5 = random_bits(1) != 0;
            addr = 32'h80 + 32'(n * 4);
            send({1'b0, f7_5, 5'b0, 1'b0, r2, 1'b0, r1, f3, rd, 7'b0110011}, addr, 1'b1);
            check(rs1_value, reg_model[r1], "rs1_value");
            check(rs2_value, reg_model[r2], "rs2_value");
            check(32'(rs1), 32'(r1), "rs1 index");
            check(32'(rs2), 32'(r2), "rs2 index");
            check(32'(rd_out), 32'(rd), "rd_out");
            check(32'(funct3), 32'(f3), "funct3");
            check(pc_out, addr, "pc_out");
            check(32'(alu_op), 32'(expected_alu(7'b0110011, f3, f7_5)), "alu_op for R-type");
            check(32'(src2_sel), 32'(sel2_reg), "src2_sel for R-type");
            check(32'(reg_wen_out), 32'd1, "reg_wen_out for R-type");
        end
    endtask

    task automatic immediate_formats;
        logic [6:0]  opc_list [9];
        logic [6:0]  opc, f7;
        logic [4:0]  r1, r2, rd;
        logic [2:0]  f3;
        logic [11:0] i12;
        logic [12:0] b13;
        logic [19:0] u20;
        logic [20:0] j21;
        logic [31:0] word, want_imm;
        src1_sel_e   want_src1;
        opc_list = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011,
                     7'b1101111, 7'b1100111, 7'b0110111, 7'b0010111};
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < 9; k++) begin
                opc = opc_list[k];
                f3  = 3'(random_bits(3));
                r1  = 5'(random_bits(5));
                r2  = 5'(random_bits(5));
                rd  = 5'(random_bits(5));
                case (opc)
                    7'b0110011: begin
                        f7       = 7'(random_bits(7));
                        word     = {f7, r2, r1, f3, rd, opc};
                        want_imm = {25'b0, f7};
                    end
                    7'b0100011: begin
                        i12      = 12'(random_bits(12));
                        word     = {i12[11:5], r2, r1, f3, i12[4:0], opc};
                        want_imm = {{20{i12[11]}}, i12};
                    end
                    7'b1100011: begin
                        if (f3[2:1] == 2'b01) f3[1] = 1'b0; // keep to real branch encodings
                        b13      = {12'(random_bits(12)), 1'b0};
                        word     = {b13[12], b13[10:5], r2, r1, f3, b13[4:1], b13[11], opc};
                        want_imm = {{19{b13[12]}}, b13};
                    end
                    7'b0110111, 7'b0010111: begin
                        u20      = 20'(random_bits(20));
                        word     = {u20, rd, opc};
                        want_imm = {u20, 12'b0};
                    end
                    7'b1101111: begin
                        j21      = {20'(random_bits(20)), 1'b0};
                        word     = {j21[20], j21[10:1], j21[11], j21[19:12], rd, opc};
                        want_imm = {{11{j21[20]}}, j21};
                    end
                    default: begin
                        i12      = 12'(random_bits(12));
                        word     = {i12, r1, f3, rd, opc};
                        want_imm = {{20{i12[11]}}, i12};
                    end
                endcase
                want_src1 = (opc == 7'b0110111) ? sel1_zero :
                            (opc == 7'b0010111 || opc == 7'b1101111) ? sel1_pc : sel1_reg;
                send(word, 32'h1000 + 32'(k * 4), 1'b1);
                check(imm, want_imm, "imm");
                check(32'(src1_sel), 32'(want_src1), "src1_sel");
                check(32'(alu_op), 32'(expected_alu(opc, f3, word[30])), "alu_op");
                check(32'(mem_wen), 32'(opc == 7'b0100011), "mem_wen");
                check(32'(mem_ren), 32'(opc == 7'b0000011), "mem_ren");
                check(32'(branch_flag), 32'(opc == 7'b1100011), "branch_flag");
                check(32'(inv_flag), 32'(opc == 7'b1100011 && f3[0]), "inv_flag");
                check(32'(jump_flag), 32'(opc == 7'b1101111 || opc == 7'b1100111), "jump_flag");
            end
        end
    endtask

    task automatic flush_bubble;
        @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        @(posedge clock); // idle, the flush has to wait
        send({12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011}, 32'h200, 1'b0);
        check(32'(reg_wen_out), 32'd0, "reg_wen_out for flushed transfer");
        send({12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011}, 32'h204, 1'b1);
        check(32'(reg_wen_out), 32'd1, "reg_wen_out after flush");
        check(imm, 32'd5, "imm after flush");
    endtask

    task automatic csr_access;
        logic [31:0] vec, trap_pc;
        vec     = random_bits(32);
        trap_pc = {30'(random_bits(30)), 2'b00};
        @(posedge clock);
        wb_csr_wen   <= 4'b1000;
        wb_csr_value <= vec;
        @(posedge clock);
        wb_csr_wen <= 4'b0000;
        @(negedge clock);
        check(mtvec_out, vec, "mtvec_out after writeback");
        send({12'h305, 5'd0, 3'b010, 5'd1, 7'b1110011}, 32'h300, 1'b1);
        check(csr_value, vec, "csr_value for mtvec");
        check(32'(src2_sel), 32'(sel2_csr_set), "src2_sel for csrrs");
        check(32'(alu_op), 32'(alu_or), "alu_op for csrrs");
        check(32'(csr_wen_out), 32'b1000, "csr_wen_out for mtvec");
        send(32'h0000_0073, trap_pc, 1'b1);
        check(32'({ecall_flag, mret_flag, fence_i_flag}), 32'b100, "flags for ecall");
        @(negedge clock);
        check(mepc_out, trap_pc, "mepc_out after ecall");
        send({12'h342, 5'd0, 3'b010, 5'd1, 7'b1110011}, trap_pc + 32'd4, 1'b1);
        check(csr_value, 32'd11, "mcause after ecall");
        send(32'h3020_0073, 32'h310, 1'b1);
        check(32'({ecall_flag, mret_flag, fence_i_flag}), 32'b010, "flags for mret");
        send(32'h0000_100f, 32'h314, 1'b1);
        check(32'({ecall_flag, mret_flag, fence_i_flag}), 32'b001, "flags for fence.i");
    endtask

    initial begin
        reset        <= 1'b1;
        flush        <= 1'b0;
        valid_in     <= 1'b0;
        ready_out    <= 1'b1;
        inst         <= '0;
        pc           <= '0;
        wb_rd        <= '0;
        wb_value     <= '0;
        wb_reg_wen   <= 1'b0;
        wb_csr_value <= '0;
        wb_csr_wen   <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        reset_and_handshake();
        register_readback();
        immediate_formats();
        flush_bubble();
        csr_access();
        repeat (2) @(posedge clock);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(RUN_CYCLES * 2 * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", RUN_CYCLES * 2);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/decode_pkg.sv
logic/inst_latch.sv
logic/ctrl_decoder.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/csr_file.sv
logic/decode_stage.sv
bench/decode_stage_sva.sv
bench/decode_stage_tb.sv

// ==== Makefile ====
TOP = decode_stage_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
